// File: Makefile
# Verilator build and run of the acquisition testbench.

TOP = tb_acq

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// File: bench/acq_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "acq_settings.svh"

module acq_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  acq_pkg::adc_beat_t       adc,
    input  logic                     fs,
    input  logic [`ACQ_ADDR_W-1:0]   base_addr,
    input  logic                     fd,
    input  logic [`ACQ_ADDR_W-1:0]   rd_addr,
    input  acq_pkg::sample_t         rd_data,
    input  logic [`ACQ_CHANNELS-1:0] fifo_empty,
    input  logic [`ACQ_CHANNELS-1:0] fifo_overflow,
    output int                       data_errs,
    output int                       flag_errs,
    output int                       timing_errs,
    output int                       read_checks
);
    localparam int channels = `ACQ_CHANNELS;
    localparam int burst_len = `ACQ_BURST_LEN;
    localparam int depth = `ACQ_FIFO_DEPTH;
    localparam int aw = `ACQ_ADDR_W;
    localparam int words = 1 << aw;
    // Edge into INIT, the INIT cycle, then WORK plus REST per pass.
    localparam int fd_delay = 2 + channels * (burst_len + 1);

    acq_pkg::sample_t model_q [channels][$];
    acq_pkg::sample_t exp_mem [words];
    bit known [words];
    logic [channels-1:0] exp_ovf;
    logic [channels-1:0] exp_empty;
    logic prev_fs;
    logic prev_fd;
    logic [aw-1:0] prev_addr;
    int cycle;
    int start_cycle;
    bit busy;

    task automatic check_read();
        if (!prev_fs && !prev_fd && known[prev_addr]) begin
            read_checks = read_checks + 1;
            if (rd_data !== exp_mem[prev_addr]) begin
                data_errs = data_errs + 1;
                $display("ERR %0t: frame[%0d] read %02h, expected %02h", $time,
                         prev_addr, rd_data, exp_mem[prev_addr]);
            end
        end
    endtask

    task automatic check_fd();
        if (fd && !prev_fd) begin
            if (!busy) begin
                timing_errs = timing_errs + 1;
                $display("ERR %0t: fd rose with no capture running", $time);
            end else if (cycle - start_cycle != fd_delay) begin
                timing_errs = timing_errs + 1;
                $display("ERR %0t: fd rose after %0d cycles, expected %0d", $time,
                         cycle - start_cycle, fd_delay);
            end
        end
        if (prev_fd && prev_fs && !fd) begin
            timing_errs = timing_errs + 1;
            $display("ERR %0t: fd fell while fs was still held", $time);
        end
        if (prev_fd && !prev_fs && fd) begin
            timing_errs = timing_errs + 1;
            $display("ERR %0t: fd still high one cycle after fs fell", $time);
        end
        if (prev_fd && !fd) begin
            busy = 1'b0;
        end
    endtask

    task automatic compare_flags();
        for (int k = 0; k < channels; k++) begin
            exp_empty[k] = (model_q[k].size() == 0);
        end
        if (fifo_empty !== exp_empty) begin
            flag_errs = flag_errs + 1;
            $display("ERR %0t: fifo_empty %b, expected %b", $time, fifo_empty, exp_empty);
        end
        if (fifo_overflow !== exp_ovf) begin
            flag_errs = flag_errs + 1;
            $display("ERR %0t: fifo_overflow %b, expected %b", $time, fifo_overflow, exp_ovf);
        end
    endtask

    task automatic record_pushes();
        for (int k = 0; k < channels; k++) begin
            if (adc.valid[k]) begin
                if (model_q[k].size() < depth) begin
                    model_q[k].push_back(adc.data[k]);
                end else begin
                    exp_ovf[k] = 1'b1; // Dropped sample.
                end
            end
        end
    endtask

    // Channel k, index j lands at base + burst_len*k + j.
    task automatic start_capture();
        logic [aw-1:0] addr;
        busy = 1'b1;
        start_cycle = cycle;
        for (int k = 0; k < channels; k++) begin
            for (int j = 0; j < burst_len; j++) begin
                addr = base_addr + aw'(k * burst_len + j);
                if (model_q[k].size() == 0) begin
                    flag_errs = flag_errs + 1;
                    $display("Capture started with channel %0d short of a full burst", k);
                end else begin
                    exp_mem[addr] = model_q[k].pop_front();
                    known[addr] = 1'b1;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < channels; k++) begin
                model_q[k].delete();
            end
            exp_ovf = '0;
            prev_fs = 1'b0;
            prev_fd = 1'b0;
            prev_addr = '0;
            busy = 1'b0;
        end else begin
            cycle = cycle + 1;
            check_read();
            check_fd();
            if (!fs && !fd) begin
                compare_flags(); // Only while the engine is idle.
            end
            record_pushes();
            if (fs && !prev_fs) begin
                start_capture();
            end
            prev_fs = fs;
            prev_fd = fd;
            prev_addr = rd_addr;
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_acq.sv
`timescale 1ns/1ps
`default_nettype none
`include "acq_settings.svh"

module tb_acq;
    localparam int channels = `ACQ_CHANNELS;
    localparam int burst_len = `ACQ_BURST_LEN;
    localparam int aw = `ACQ_ADDR_W;
    localparam int frame_len = channels * burst_len;
    localparam int rows = 5;
    localparam int fd_limit = 1000;
    localparam int fall_limit = 10;
    localparam int hold_cycles = 5;

    typedef struct packed {
        logic [aw-1:0] base;
        logic [7:0]    fill; // Pushed into every channel.
        logic [2:0]    xch;
        logic [7:0]    xcnt; // Extra pushes on xch.
    } row_t;

    row_t stim [rows] = '{
        '{12'd0,    8'd32, 3'd0, 8'd0},  // One burst each, drains empty.
        '{12'd4064, 8'd64, 3'd0, 8'd0},  // Wraps, leaves a burst behind.
        '{12'd100,  8'd0,  3'd0, 8'd0},  // Leftovers only.
        '{12'd1000, 8'd64, 3'd5, 8'd6},  // Channel 5 overflows.
        '{12'd2500, 8'd0,  3'd0, 8'd0}
    };

    logic clk;
    logic rst;
    acq_pkg::adc_beat_t adc;
    logic fs;
    logic [aw-1:0] base_addr;
    logic fd;
    logic [aw-1:0] rd_addr;
    acq_pkg::sample_t rd_data;
    logic [channels-1:0] fifo_empty;
    logic [channels-1:0] fifo_overflow;
    int data_errs;
    int flag_errs;
    int timing_errs;
    int read_checks;
    int timeouts;
    int short_reads;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    acq_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .adc          (adc),
        .fs           (fs),
        .base_addr    (base_addr),
        .fd           (fd),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .fifo_empty   (fifo_empty),
        .fifo_overflow(fifo_overflow)
    );

    acq_checker u_chk (
        .clk          (clk),
        .rst          (rst),
        .adc          (adc),
        .fs           (fs),
        .base_addr    (base_addr),
        .fd           (fd),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .fifo_empty   (fifo_empty),
        .fifo_overflow(fifo_overflow),
        .data_errs    (data_errs),
        .flag_errs    (flag_errs),
        .timing_errs  (timing_errs),
        .read_checks  (read_checks)
    );

    task automatic push_samples(input int ch, input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            adc.valid = '0;
            adc.valid[ch] = 1'b1;
            adc.data[ch] = acq_pkg::sample_t'($urandom);
        end
        @(negedge clk);
        adc.valid = '0;
    endtask

    task automatic wait_fd(input logic level, input int limit, output bit ok);
        int n;
        n = 0;
        while (fd !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        ok = (fd === level);
    endtask

    task automatic run_capture(input int r, output bit ok);
        bit up;
        bit down;
        @(negedge clk);
        base_addr = stim[r].base;
        fs = 1'b1;
        wait_fd(1'b1, fd_limit, up);
        if (!up) begin
            $display("Timeout: fd never rose during capture %0d", r);
            ok = 1'b0;
        end else begin
            repeat (hold_cycles) @(negedge clk); // fd has to hold meanwhile.
            fs = 1'b0;
            wait_fd(1'b0, fall_limit, down);
            if (!down) begin
                $display("Timeout: fd did not fall after fs dropped in capture %0d", r);
            end
            ok = down;
        end
    endtask

    task automatic read_frame(input logic [aw-1:0] base);
        for (int a = 0; a < frame_len; a++) begin
            @(negedge clk);
            rd_addr = base + aw'(a);
        end
        repeat (2) @(negedge clk);
    endtask

    initial begin
        int n_push;
        int total;
        bit ok;
        void'($urandom(32'h80c5));
        rst = 1'b1;
        adc = '0;
        fs = 1'b0;
        base_addr = '0;
        rd_addr = '0;
        timeouts = 0;
        short_reads = 0;
        ok = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk); // Idle flags after reset.
        for (int r = 0; r < rows && ok; r++) begin
            for (int k = 0; k < channels; k++) begin
                n_push = int'(stim[r].fill);
                if (k == int'(stim[r].xch)) begin
                    n_push = n_push + int'(stim[r].xcnt);
                end
                push_samples(k, n_push);
            end
            run_capture(r, ok);
            if (ok) begin
                read_frame(stim[r].base);
            end else begin
                timeouts++;
            end
        end
        repeat (3) @(negedge clk);
        if (read_checks < rows * frame_len) begin
            short_reads = 1;
            $display("Fewer frame reads were compared than the testbench issued");
        end
        total = data_errs + flag_errs + timing_errs + timeouts + short_reads;
        $display("Errors: data %0d, flags %0d, timing %0d, timeouts %0d, short %0d; reads %0d",
                 data_errs, flag_errs, timing_errs, timeouts, short_reads, read_checks);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/acq_pkg.sv
`default_nettype none
`include "acq_settings.svh"

package acq_pkg;

    typedef logic [`ACQ_SAMPLE_W-1:0] sample_t;

    // One cycle of ADC strobes, channel k in valid[k] and data[k].
    typedef struct packed {
        logic [`ACQ_CHANNELS-1:0] valid;
        sample_t [`ACQ_CHANNELS-1:0] data;
    } adc_beat_t;

    // One frame RAM write.
    typedef struct packed {
        logic en;
        logic [`ACQ_ADDR_W-1:0] addr;
        sample_t data;
    } ram_wr_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT,
        INIT,
        WORK,
        REST,
        DONE
    } drain_state_t;

endpackage

`default_nettype wire

// File: hw/acq_settings.svh
`ifndef ACQ_SETTINGS_SVH
`define ACQ_SETTINGS_SVH

// Number of ADC channels.
`define ACQ_CHANNELS 8

// Samples taken from each channel per capture.
`define ACQ_BURST_LEN 32

// Sample width in bits.
`define ACQ_SAMPLE_W 8

// Frame RAM address width, 4096 entries.
`define ACQ_ADDR_W 12

// Entries per channel FIFO, never below ACQ_BURST_LEN.
`define ACQ_FIFO_DEPTH 64

`endif

// File: hw/acq_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "acq_settings.svh"

module acq_top (
    input  logic                     clk,
    input  logic                     rst,
    input  acq_pkg::adc_beat_t       adc,
    input  logic                     fs,
    input  logic [`ACQ_ADDR_W-1:0]   base_addr,
    output logic                     fd,
    input  logic [`ACQ_ADDR_W-1:0]   rd_addr,
    output acq_pkg::sample_t         rd_data,
    output logic [`ACQ_CHANNELS-1:0] fifo_empty,
    output logic [`ACQ_CHANNELS-1:0] fifo_overflow
);
    localparam int channels = `ACQ_CHANNELS;
    localparam int sw = `ACQ_SAMPLE_W;

    logic [channels-1:0] fifo_rden;
    logic [channels*sw-1:0] fifo_heads;
    acq_pkg::ram_wr_t ram_wr;

    if (`ACQ_FIFO_DEPTH < `ACQ_BURST_LEN) begin : g_depth_check
        $error("acq_top: FIFO depth below burst length.");
    end

    // Channel 0 sits in the top slice and the top read enable bit.
    for (genvar k = 0; k < channels; k++) begin : g_fifo
        sample_fifo #(
            .depth(`ACQ_FIFO_DEPTH)
        ) u_fifo (
            .clk      (clk),
            .rst      (rst),
            .push     (adc.valid[k]),
            .push_data(adc.data[k]),
            .pop      (fifo_rden[channels-1-k]),
            .head     (fifo_heads[(channels-1-k)*sw +: sw]),
            .empty    (fifo_empty[k]),
            .overflow (fifo_overflow[k])
        );
    end

    burst_drain u_drain (
        .clk       (clk),
        .rst       (rst),
        .fs        (fs),
        .fd        (fd),
        .base_addr (base_addr),
        .fifo_rden (fifo_rden),
        .fifo_heads(fifo_heads),
        .ram_wr    (ram_wr)
    );

    frame_ram u_ram (
        .clk    (clk),
        .ram_wr (ram_wr),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

endmodule

`default_nettype wire

// File: hw/burst_drain.sv
`timescale 1ns/1ps
`default_nettype none
`include "acq_settings.svh"

module burst_drain (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      fs,
    output logic                                      fd,
    input  logic [`ACQ_ADDR_W-1:0]                    base_addr,
    output logic [`ACQ_CHANNELS-1:0]                  fifo_rden,
    input  logic [`ACQ_CHANNELS*`ACQ_SAMPLE_W-1:0]    fifo_heads,
    output acq_pkg::ram_wr_t                          ram_wr
);
    localparam int channels = `ACQ_CHANNELS;
    localparam int burst_len = `ACQ_BURST_LEN;
    localparam int sw = `ACQ_SAMPLE_W;
    localparam int dw = (burst_len > 1) ? $clog2(burst_len) : 1;
    localparam int cw = (channels > 1) ? $clog2(channels) : 1;
    localparam logic [dw-1:0] data_last = dw'(burst_len - 1);
    localparam logic [cw-1:0] chan_last = cw'(channels - 1);
    // Channel 0 owns the top read enable bit.
    localparam logic [channels-1:0] rden_ch0 = {1'b1, {(channels - 1){1'b0}}};

    acq_pkg::drain_state_t state;
    acq_pkg::drain_state_t next_state;
    logic [dw-1:0] data_cnt;
    logic [cw-1:0] chan_cnt;
    logic [`ACQ_ADDR_W-1:0] wr_addr;
    logic [cw-1:0] slice_sel;
    logic work;

    assign work = (state == acq_pkg::WORK);
    assign fd = (state == acq_pkg::DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= acq_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            acq_pkg::IDLE: next_state = acq_pkg::WAIT;
            acq_pkg::WAIT: begin
                if (fs) begin
                    next_state = acq_pkg::INIT;
                end
            end
            acq_pkg::INIT: next_state = acq_pkg::WORK;
            acq_pkg::WORK: begin
                if (data_cnt == data_last) begin
                    next_state = acq_pkg::REST;
                end
            end
            acq_pkg::REST: begin
                // Last channel done, else next pass.
                next_state = (chan_cnt == chan_last) ? acq_pkg::DONE : acq_pkg::WORK;
            end
            acq_pkg::DONE: begin
                if (!fs) begin
                    next_state = acq_pkg::WAIT;
                end
            end
            default: next_state = acq_pkg::IDLE;
        endcase
    end

    // Sample index within the current burst.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_cnt <= '0;
        end else if (work) begin
            data_cnt <= data_cnt + 1'b1;
        end else begin
            data_cnt <= '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            chan_cnt <= '0;
        end else if (state == acq_pkg::INIT) begin
            chan_cnt <= '0;
        end else if (state == acq_pkg::REST) begin
            chan_cnt <= chan_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_addr <= '0;
        end else if (state == acq_pkg::INIT) begin
            wr_addr <= base_addr;
        end else if (work) begin
            wr_addr <= wr_addr + 1'b1; // Wraps at the top of the RAM.
        end
    end

    assign slice_sel = chan_last - chan_cnt;
    assign fifo_rden = work ? (rden_ch0 >> chan_cnt) : '0;

    assign ram_wr.en = work;
    assign ram_wr.addr = wr_addr;
    assign ram_wr.data = fifo_heads[slice_sel*sw +: sw];

    // Read enable stays on one channel for the whole burst.
    assert property (@(posedge clk) disable iff (rst)
        work && $past(work) |-> fifo_rden == $past(fifo_rden))
        else $error("burst_drain: read enable left its channel mid-burst at %0t", $time);

    // Writes within a burst land on consecutive addresses.
    assert property (@(posedge clk) disable iff (rst)
        ram_wr.en && (data_cnt != data_last)
        |=> ram_wr.en && (ram_wr.addr == $past(ram_wr.addr) + 1'b1))
        else $error("burst_drain: write address skipped within a burst at %0t", $time);

endmodule

`default_nettype wire

// File: hw/frame_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "acq_settings.svh"

module frame_ram (
    input  logic                   clk,
    input  acq_pkg::ram_wr_t       ram_wr,
    input  logic [`ACQ_ADDR_W-1:0] rd_addr,
    output acq_pkg::sample_t       rd_data
);
    localparam int words = 1 << `ACQ_ADDR_W;

    acq_pkg::sample_t mem [words];

    // Write port, driven by the drain engine.
    always_ff @(posedge clk) begin
        if (ram_wr.en) begin
            mem[ram_wr.addr] <= ram_wr.data;
        end
    end

    // Host read, one cycle latency.
    // Same-address collision returns the old word.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: hw/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "acq_settings.svh"

module sample_fifo #(
    parameter int depth = `ACQ_FIFO_DEPTH
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  acq_pkg::sample_t push_data,
    input  logic             pop,
    output acq_pkg::sample_t head,
    output logic             empty,
    output logic             overflow
);
    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    localparam int cw = $clog2(depth + 1);
    localparam logic [aw-1:0] ptr_last = aw'(depth - 1);

    acq_pkg::sample_t mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [cw-1:0] count;
    logic full;
    logic do_push;
    logic do_pop;

    assign full = (count == cw'(depth));
    assign empty = (count == '0);
    assign do_push = push && !full; // Dropped when full.
    assign do_pop = pop && !empty;
    assign head = mem[rd_ptr]; // Fall-through head.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && full) begin
                overflow <= 1'b1; // Sticky until reset.
            end
        end
    end

    // Drain engine must never consume from an empty channel.
    assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("sample_fifo: pop while empty at %0t", $time);

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/acq_pkg.sv
hw/sample_fifo.sv
hw/burst_drain.sv
hw/frame_ram.sv
hw/acq_top.sv
bench/acq_checker.sv
bench/tb_acq.sv
